// ==== dv/fetch_props.sv ====
// Assertions on the instruction SRAM read channels, bound into isram by the testbench
module fetch_props
  import fetch_pkg::*;
(
  input logic  clk,
  input logic  rst,
  input addr_t isram_araddr,
  input logic  isram_arvalid,
  input logic  isram_arready,
  input resp_t isram_rresp,
  input logic  isram_rvalid,
  input word_t isram_rdata,
  input logic  isram_rready
);

  int unsigned fail_count = 0;  // Failed assertions so far

  // ------------------------------------------------------------
  // Handshake stability
  // ------------------------------------------------------------
  ar_stable: assert property (@(posedge clk) disable iff (rst)
    isram_arvalid && !isram_arready |=> isram_arvalid && $stable(isram_araddr))
    else begin
      fail_count++;
      $error("AR request changed before it was accepted");
    end

  r_stable: assert property (@(posedge clk) disable iff (rst)
    isram_rvalid && !isram_rready |=>
      isram_rvalid && $stable(isram_rdata) && $stable(isram_rresp))
    else begin
      fail_count++;
      $error("R response changed before it was taken");
    end

  // Only one read outstanding
  single_read: assert property (@(posedge clk) disable iff (rst)
    isram_rvalid |-> !isram_arready)
    else begin
      fail_count++;
      $error("arready high while read data is pending");
    end

  // Both channels quiet right after a reset edge
  reset_quiet: assert property (@(posedge clk)
    rst |=> !isram_arready && !isram_rvalid)
    else begin
      fail_count++;
      $error("arready or rvalid high after reset");
    end

endmodule

// ==== dv/fetch_tb.sv ====
// Testbench for fetch_top, loads programs under reset and checks fetched instructions
module fetch_tb
  import fetch_pkg::*;
();

  localparam int SEQ_STEPS    = 16;
  localparam int JAL_STEPS    = 12;
  localparam int REDIR_BEFORE = 2;
  localparam int REDIR_AFTER  = 6;
  localparam int ERR_BEFORE   = 3;   // Up to and including the faulting fetch
  localparam int ERR_AFTER    = 4;
  localparam int TOTAL_INSTS  = 2 * SEQ_STEPS + JAL_STEPS + REDIR_BEFORE + REDIR_AFTER
                                + ERR_BEFORE + ERR_AFTER;
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_INSTS;

  logic       clk;
  logic       rst;
  logic       load_en;
  isram_idx_t load_idx;
  word_t      load_data;
  logic       id_allowin;
  logic       redirect_valid;
  addr_t      redirect_pc;
  logic       inst_valid;
  word_t      inst;
  addr_t      inst_pc;
  logic       inst_err;

  word_t  image [ISRAM_WORDS];  // Mirror of what was loaded into the SRAM
  addr_t  exp_pc[$];
  word_t  exp_inst[$];
  logic   exp_err[$];
  string  test_name;
  int     seed;
  logic   stalled;
  word_t  held_inst;
  addr_t  held_pc;

  fetch_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .load_en        (load_en),
    .load_idx       (load_idx),
    .load_data      (load_data),
    .id_allowin     (id_allowin),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .inst_err       (inst_err)
  );

  bind isram fetch_props props_i (
    .clk           (clk),
    .rst           (rst),
    .isram_araddr  (isram_araddr),
    .isram_arvalid (isram_arvalid),
    .isram_arready (isram_arready),
    .isram_rresp   (isram_rresp),
    .isram_rvalid  (isram_rvalid),
    .isram_rdata   (isram_rdata),
    .isram_rready  (isram_rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reporting and checking
  // ------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("Timeout, fetch stopped delivering the expected instructions");
  end

  always @(negedge clk) begin
    if (dut_i.isram_i.props_i.fail_count != 0) begin
      fail_run("Assertion on the SRAM read channels failed");
    end
  end

  // ------------------------------------------------------------
  // Program encoding and reference model
  // ------------------------------------------------------------
  function automatic word_t addi_word(input int tag);
    return {12'(tag), 5'd1, 3'd0, 5'd1, 7'h13};  // addi x1, x1, tag
  endfunction

  function automatic word_t jal_word(input int offset);
    logic [20:0] imm;
    imm = 21'(offset);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
  endfunction

  // Scatter the J-type fields back into a byte offset
  function automatic addr_t jal_offset(input word_t w);
    logic [20:0] imm;
    imm[20]    = w[31];
    imm[19:12] = w[19:12];
    imm[11]    = w[20];
    imm[10:1]  = w[30:21];
    imm[0]     = 1'b0;
    return {{11{imm[20]}}, imm};
  endfunction

  task automatic model_walk(input addr_t start, input int steps);
    addr_t pc;
    addr_t off;
    word_t w;
    logic  err;
    pc = start;
    for (int i = 0; i < steps; i++) begin
      off = pc - RESET_PC;
      err = (off >= ISRAM_WORDS * 4) || (pc[1:0] != 2'b00);
      w   = err ? 32'h0 : image[off >> 2];
      exp_pc.push_back(pc);
      exp_inst.push_back(w);
      exp_err.push_back(err);
      if (err) break;  // Fetch halts on an error
      pc = (w[6:0] == OPC_JAL) ? pc + jal_offset(w) : pc + 32'd4;
    end
  endtask

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  task automatic reset_and_load(input int first, input int last);
    rst            = 1'b1;
    id_allowin     = 1'b0;
    redirect_valid = 1'b0;
    for (int i = first; i <= last; i++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_idx  = isram_idx_t'(i);
      load_data = image[i];
    end
    @(negedge clk);
    load_en = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic run_until_drained(input bit random_allow);
    while (exp_pc.size() != 0) begin
      id_allowin = random_allow ? (($random(seed) % 2) != 0) : 1'b1;
      @(negedge clk);
    end
    id_allowin = 1'b0;
  endtask

  task automatic pulse_redirect(input addr_t target);
    id_allowin     = 1'b0;
    redirect_valid = 1'b1;
    redirect_pc    = target;
    @(negedge clk);
    redirect_valid = 1'b0;
  endtask

  task automatic build_straight();
    for (int i = 0; i < 48; i++) image[i] = addi_word(i + 1);
  endtask

  // Consumes at each edge where the downstream stage accepts
  always @(posedge clk) begin : monitor
    if (rst) begin
      stalled <= 1'b0;
    end else begin
      if (stalled) begin
        check_equal("held inst_valid", 32'd1, inst_valid);
        check_equal("held inst", held_inst, inst);
        check_equal("held inst_pc", held_pc, inst_pc);
      end
      if (inst_valid && id_allowin) begin
        if (exp_pc.size() == 0) begin
          fail_run("Instruction delivered while none was expected");
        end else begin
          check_equal("inst_pc", exp_pc.pop_front(), inst_pc);
          check_equal("inst", exp_inst.pop_front(), inst);
          check_equal("inst_err", exp_err.pop_front(), inst_err);
        end
      end
      stalled   <= inst_valid && !id_allowin && !redirect_valid;
      held_inst <= inst;
      held_pc   <= inst_pc;
    end
  end

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_sequential();
    test_name = "test_sequential";
    build_straight();
    reset_and_load(0, 47);
    model_walk(RESET_PC, SEQ_STEPS);
    run_until_drained(1'b0);
  endtask

  task automatic test_jal();
    test_name = "test_jal";
    for (int i = 0; i < 14; i++) image[i] = addi_word(200 + i);
    image[1]  = jal_word(12);   // Forward to word 4
    image[5]  = jal_word(20);   // Forward to word 10
    image[11] = jal_word(-36);  // Back to word 2
    reset_and_load(0, 13);
    model_walk(RESET_PC, JAL_STEPS);
    run_until_drained(1'b0);
  endtask

  task automatic test_backpressure();
    test_name = "test_backpressure";
    build_straight();
    reset_and_load(0, 47);
    model_walk(RESET_PC, SEQ_STEPS);
    run_until_drained(1'b1);
  endtask

  task automatic test_redirect();
    addr_t target;
    test_name = "test_redirect";
    target    = RESET_PC + 32'd160;  // Word 40
    build_straight();
    reset_and_load(0, 47);
    model_walk(RESET_PC, REDIR_BEFORE);
    run_until_drained(1'b0);
    while (!dut_i.isram_arvalid) @(negedge clk);  // Old-path read about to go out
    pulse_redirect(target);
    model_walk(target, REDIR_AFTER);
    run_until_drained(1'b0);
  endtask

  task automatic test_range_error();
    test_name = "test_range_error";
    for (int i = 0; i < 14; i++) image[i] = addi_word(300 + i);
    image[1] = jal_word(8192);  // Lands past the end of the SRAM
    reset_and_load(0, 13);
    model_walk(RESET_PC, ERR_BEFORE);
    run_until_drained(1'b0);
    id_allowin = 1'b1;
    repeat (20) @(negedge clk);  // Fetch must stay halted
    pulse_redirect(RESET_PC + 32'd32);
    model_walk(RESET_PC + 32'd32, ERR_AFTER);
    run_until_drained(1'b0);
  endtask

  initial begin
    rst            = 1'b1;
    load_en        = 1'b0;
    load_idx       = '0;
    load_data      = '0;
    id_allowin     = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    seed           = 32'hedd8782a;
    test_sequential();
    test_jal();
    test_backpressure();
    test_redirect();
    test_range_error();
    repeat (5) @(negedge clk);
    if (dut_i.isram_i.props_i.fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_run("Assertion on the SRAM read channels failed");
    end
  end

endmodule

// ==== files.f ====
verilog/fetch_pkg.sv
verilog/isram.sv
verilog/fetch_npc.sv
verilog/ifu.sv
verilog/fetch_top.sv
dv/fetch_props.sv
dv/fetch_tb.sv

// ==== verilog/fetch_npc.sv ====
// Static next-PC logic for fetch, follows JAL targets and otherwise steps to the next word
module fetch_npc
  import fetch_pkg::*;
(
  input  addr_t pc,    // Address of the returned word
  input  word_t inst,  // Returned instruction word
  output addr_t npc    // Address of the following fetch
);

  logic [6:0] opcode;
  logic       is_jal;
  addr_t      j_imm;
  addr_t      jal_target;
  addr_t      seq_pc;

  assign opcode = inst[6:0];
  assign is_jal = opcode == OPC_JAL;

  // ------------------------------------------------------------
  // J-type immediate, imm[20|10:1|11|19:12] in inst[31:12]
  // ------------------------------------------------------------
  always_comb begin
    j_imm = {
      {11{inst[31]}},  // Sign extension
      inst[31],        // imm[20]
      inst[19:12],     // imm[19:12]
      inst[20],        // imm[11]
      inst[30:21],     // imm[10:1]
      1'b0             // Always halfword aligned
    };
  end

  assign jal_target = pc + j_imm;
  assign seq_pc     = pc + 32'd4;

  // Only unconditional jumps are followed here
  always_comb begin
    if (is_jal) begin
      npc = jal_target;
    end else begin
      npc = seq_pc;
    end
  end

endmodule

// ==== verilog/fetch_pkg.sv ====
// Shared types, memory map and state encodings for the instruction fetch subsystem
package fetch_pkg;

  // ------------------------------------------------------------
  // Basic widths
  // ------------------------------------------------------------
  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] word_t;  // Instruction or data word
  typedef logic [1:0]  resp_t;  // Read response code

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // ------------------------------------------------------------
  // Instruction SRAM geometry and memory map
  // ------------------------------------------------------------
  localparam int ISRAM_WORDS = 1024;
  localparam int ISRAM_AW    = 10;  // Word index width

  typedef logic [ISRAM_AW-1:0] isram_idx_t;

  localparam addr_t RESET_PC    = 32'h8000_0000;
  localparam addr_t ISRAM_BYTES = addr_t'(ISRAM_WORDS * 4);  // Size of mapped window

  localparam logic [6:0] OPC_JAL = 7'b110_1111;

  // SRAM read channel sequencing
  typedef enum logic [2:0] {
    IDLE         = 3'd0,
    WAIT_ARVALID = 3'd1,
    SHAKED_AR    = 3'd2,
    WAIT_RREADY  = 3'd3,
    SHAKED_R     = 3'd4
  } isram_state_e;

  // Fetch unit sequencing
  typedef enum logic [1:0] {
    RESET_WAIT = 2'd0,  // Idle after reset, or halted after a fetch error
    ISSUE      = 2'd1,  // arvalid up, waiting for arready
    WAIT_RESP  = 2'd2,  // Address taken, waiting for read data
    HOLD       = 2'd3   // Response captured, moves to output next edge
  } ifu_state_e;

endpackage

// ==== verilog/fetch_top.sv ====
// Top of the fetch subsystem, joins fetch unit, next-PC logic and instruction SRAM
module fetch_top
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // Program loader
  input  logic       load_en,
  input  isram_idx_t load_idx,
  input  word_t      load_data,
  // Downstream stage
  input  logic       id_allowin,
  input  logic       redirect_valid,
  input  addr_t      redirect_pc,
  output logic       inst_valid,
  output word_t      inst,
  output addr_t      inst_pc,
  output logic       inst_err
);

  // ------------------------------------------------------------
  // SRAM channel and next-PC wiring
  // ------------------------------------------------------------
  addr_t isram_araddr;
  logic  isram_arvalid;
  logic  isram_arready;
  resp_t isram_rresp;
  logic  isram_rvalid;
  word_t isram_rdata;
  logic  isram_rready;
  addr_t npc_pc;
  word_t npc_inst;
  addr_t npc;

  ifu ifu_i (
    .clk            (clk),
    .rst            (rst),
    .isram_araddr   (isram_araddr),
    .isram_arvalid  (isram_arvalid),
    .isram_arready  (isram_arready),
    .isram_rresp    (isram_rresp),
    .isram_rvalid   (isram_rvalid),
    .isram_rdata    (isram_rdata),
    .isram_rready   (isram_rready),
    .npc_pc         (npc_pc),
    .npc_inst       (npc_inst),
    .npc            (npc),
    .id_allowin     (id_allowin),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .inst_valid     (inst_valid),
    .inst           (inst),
    .inst_pc        (inst_pc),
    .inst_err       (inst_err)
  );

  fetch_npc npc_i (
    .pc   (npc_pc),
    .inst (npc_inst),
    .npc  (npc)
  );

  isram isram_i (
    .clk           (clk),
    .rst           (rst),
    .load_en       (load_en),
    .load_idx      (load_idx),
    .load_data     (load_data),
    .isram_araddr  (isram_araddr),
    .isram_arvalid (isram_arvalid),
    .isram_arready (isram_arready),
    .isram_rresp   (isram_rresp),
    .isram_rvalid  (isram_rvalid),
    .isram_rdata   (isram_rdata),
    .isram_rready  (isram_rready)
  );

endmodule

// ==== verilog/ifu.sv ====
// Fetch unit, walks the PC, issues one SRAM read at a time and buffers one instruction for decode
module ifu
  import fetch_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // SRAM read address channel
  output addr_t isram_araddr,
  output logic  isram_arvalid,
  input  logic  isram_arready,
  // SRAM read data channel
  input  resp_t isram_rresp,
  input  logic  isram_rvalid,
  input  word_t isram_rdata,
  output logic  isram_rready,
  // Next-PC block
  output addr_t npc_pc,
  output word_t npc_inst,
  input  addr_t npc,
  // Downstream stage
  input  logic  id_allowin,
  input  logic  redirect_valid,
  input  addr_t redirect_pc,
  output logic  inst_valid,
  output word_t inst,
  output addr_t inst_pc,
  output logic  inst_err
);

  ifu_state_e state;
  addr_t      fetch_pc;    // Address of the read being issued or in flight
  addr_t      redir_pc_q;  // Target saved while a stale read drains
  logic       stale;
  logic       halted;
  word_t      hold_data;
  logic       hold_err;
  logic       ar_hs;
  logic       r_hs;
  logic       buf_free;
  logic       drop;
  logic       hold_load;

  // ------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------
  assign ar_hs     = isram_arvalid && isram_arready;
  assign r_hs      = isram_rvalid && isram_rready;
  assign buf_free  = !inst_valid || id_allowin;  // Empty, or drained this edge
  assign drop      = stale || redirect_valid;    // Response belongs to the old path
  assign hold_load = (state == HOLD) && !redirect_valid;

  assign isram_araddr  = fetch_pc;
  assign isram_arvalid = state == ISSUE;
  assign isram_rready  = buf_free || drop;  // Stale data is always taken

  assign npc_pc   = fetch_pc;
  assign npc_inst = hold_data;

  // ------------------------------------------------------------
  // Control FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RESET_WAIT;
      fetch_pc   <= RESET_PC;
      stale      <= 1'b0;
      halted     <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      if (redirect_valid || (inst_valid && id_allowin)) inst_valid <= 1'b0;
      if (hold_load) inst_valid <= 1'b1;  // Buffer is known empty in HOLD

      case (state)
        RESET_WAIT: begin
          if (redirect_valid) begin
            fetch_pc <= redirect_pc;
            halted   <= 1'b0;
            state    <= ISSUE;
          end else if (!halted) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          // araddr must hold until accepted, so the new target waits in redir_pc_q
          if (redirect_valid) stale <= 1'b1;
          if (ar_hs) state <= WAIT_RESP;
        end
        WAIT_RESP: begin
          if (r_hs) begin
            if (drop) begin
              stale    <= 1'b0;
              fetch_pc <= redirect_valid ? redirect_pc : redir_pc_q;
              state    <= ISSUE;
            end else begin
              state <= HOLD;
            end
          end else if (redirect_valid) begin
            stale <= 1'b1;
          end
        end
        HOLD: begin
          if (redirect_valid) begin
            fetch_pc <= redirect_pc;  // Captured word is discarded
            state    <= ISSUE;
          end else if (hold_err) begin
            halted <= 1'b1;  // Wait here for a redirect
            state  <= RESET_WAIT;
          end else begin
            fetch_pc <= npc;
            state    <= ISSUE;
          end
        end
        default: state <= RESET_WAIT;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Response capture and output buffer
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (redirect_valid) redir_pc_q <= redirect_pc;
    if (r_hs) begin
      hold_data <= isram_rdata;
      hold_err  <= isram_rresp != RESP_OKAY;
    end
    if (hold_load) begin
      inst     <= hold_data;
      inst_pc  <= fetch_pc;
      inst_err <= hold_err;
    end
  end

endmodule

// ==== verilog/isram.sv ====
// Simulated instruction SRAM, loaded by a write strobe and read over an AR/R valid/ready channel
module isram
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  // Program loader
  input  logic       load_en,
  input  isram_idx_t load_idx,
  input  word_t      load_data,
  // Read address channel
  input  addr_t      isram_araddr,
  input  logic       isram_arvalid,
  output logic       isram_arready,
  // Read data channel
  output resp_t      isram_rresp,
  output logic       isram_rvalid,
  output word_t      isram_rdata,
  input  logic       isram_rready
);

  word_t        mem [ISRAM_WORDS];
  isram_state_e state;
  isram_state_e next;
  addr_t        offset;
  isram_idx_t   rd_idx;
  logic         in_range;
  logic         aligned;
  logic         ar_hs;

  // ------------------------------------------------------------
  // Program load port
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load_en) mem[load_idx] <= load_data;
  end

  // ------------------------------------------------------------
  // Read FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= next;
    end
  end

  always_comb begin
    next = IDLE;
    case (state)
      IDLE: begin
        if (!isram_arready) next = IDLE;  // Still coming out of reset
        else if (!isram_arvalid) next = WAIT_ARVALID;
        else next = SHAKED_AR;
      end
      WAIT_ARVALID: begin
        if (isram_arvalid) next = SHAKED_AR;
        else next = WAIT_ARVALID;
      end
      SHAKED_AR: begin
        if (!isram_rvalid) next = SHAKED_AR;
        else if (!isram_rready) next = WAIT_RREADY;
        else next = SHAKED_R;
      end
      WAIT_RREADY: begin
        if (isram_rready) next = SHAKED_R;
        else next = WAIT_RREADY;
      end
      SHAKED_R: begin
        if (!isram_arready) next = IDLE;
        else if (!isram_arvalid) next = WAIT_ARVALID;
        else next = SHAKED_AR;
      end
      default: next = IDLE;
    endcase
  end

  // Handshake flags come straight from the next state
  always_ff @(posedge clk) begin
    if (rst) begin
      isram_arready <= 1'b0;
      isram_rvalid  <= 1'b0;
    end else begin
      // One read at a time, address channel closed until data is taken
      isram_arready <= (next == IDLE) || (next == WAIT_ARVALID) || (next == SHAKED_R);
      isram_rvalid  <= (next == SHAKED_AR) || (next == WAIT_RREADY);
    end
  end

  // ------------------------------------------------------------
  // Address decode and read data
  // ------------------------------------------------------------
  assign ar_hs    = isram_arvalid && isram_arready;
  assign offset   = isram_araddr - RESET_PC;  // Wraps high for addresses below the window
  assign in_range = offset < ISRAM_BYTES;
  assign aligned  = isram_araddr[1:0] == 2'b00;
  assign rd_idx   = offset[ISRAM_AW+1:2];

  // Data and response held until the R transfer
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      if (in_range && aligned) begin
        isram_rdata <= mem[rd_idx];
        isram_rresp <= RESP_OKAY;
      end else begin
        isram_rdata <= '0;           // Nothing leaks out on a bad address
        isram_rresp <= RESP_SLVERR;
      end
    end
  end

endmodule
